/* Makefile */
SIM     = verilator
FLAGS   = --binary --assert
TOP     = tb_wdt_top
FLIST   = flist.f
OBJ_DIR = obj_dir
LOG     = sim.log

SRCS    = $(filter-out +%,$(shell cat $(FLIST))) source/wdt_macros.svh
BIN     = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* flist.f */
+incdir+source
source/wdt_bus_pkg.sv
source/wdt_ctl_pkg.sv
source/wdt_regs.sv
source/wdt_counter.sv
source/wdt_status.sv
source/wdt_top.sv
verification/tb_wdt_top.sv

/* source/wdt_bus_pkg.sv */
/* Peripheral bus types
   One request word and the data word of the 16-bit bus */

`include "wdt_macros.svh"

package wdt_bus_pkg;

  // Data word on both directions of the bus
  typedef logic [`WDT_DATA_W-1:0] per_data_t;

  // One bus request, sampled on rising mclk
  typedef struct packed {
    // Word address in byte units without bit 0 of the byte address
    logic [`WDT_ADDR_W-1:0] addr;
    // Write data
    per_data_t              din;
    // Access enable
    logic                   en;
    // Byte write enables, all zero on a read
    logic [1:0]             we;
  } per_req_t;

endpackage

/* source/wdt_counter.sv */
/* Watchdog counter
   Selects the clock enable, counts ticks and detects the interval end */

`timescale 1ns/1ns
`include "wdt_macros.svh"

module wdt_counter
  import wdt_ctl_pkg::*;
(
  input  logic    mclk,
  input  logic    puc_rst,
  input  wdtctl_t wdtctl,
  input  logic    smclk_en,
  input  logic    aclk_en,
  input  logic    dbg_freeze,
  input  logic    cnt_clr_sw,
  input  logic    pw_error,
  output logic    interval_evt
);

  logic [`WDT_CNT_W-1:0] cnt;
  logic [`WDT_CNT_W-1:0] cnt_nxt;
  logic                  src_en;
  logic                  tick;
  logic                  tap_bit;
  logic                  cnt_clr;

  ////////////////////////////////////////////////////////////
  // Tick generation
  ////////////////////////////////////////////////////////////

  // Source enable by SSEL
  assign src_en = wdtctl.ssel ? aclk_en : smclk_en;

  // Hold bit and debugger both stop the count
  assign tick = ~wdtctl.hold & ~dbg_freeze & src_en;

  assign cnt_nxt = cnt + {{(`WDT_CNT_W-1){1'b0}}, 1'b1};

  ////////////////////////////////////////////////////////////
  // Interval tap
  ////////////////////////////////////////////////////////////

  // Look at the next value so the event lands on tick 2^tap
  always_comb begin
    case (wdtctl.is)
      is_32k:  tap_bit = cnt_nxt[`WDT_TAP_0];
      is_8k:   tap_bit = cnt_nxt[`WDT_TAP_1];
      is_512:  tap_bit = cnt_nxt[`WDT_TAP_2];
      default: tap_bit = cnt_nxt[`WDT_TAP_3];
    endcase
  end

  assign interval_evt = tick & tap_bit;

  ////////////////////////////////////////////////////////////
  // Counter
  ////////////////////////////////////////////////////////////

  // Software clear, bad key or end of interval
  assign cnt_clr = cnt_clr_sw | pw_error | interval_evt;

  // Clear wins over a tick
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      cnt <= '0;
    end else if (cnt_clr) begin
      cnt <= '0;
    end else if (tick) begin
      cnt <= cnt_nxt;
    end
  end

endmodule

/* source/wdt_ctl_pkg.sv */
/* Watchdog control types
   WDTCTL fields, interval select and interrupt flag strobes */

package wdt_ctl_pkg;

  // Interval select, count of ticks per interval
  typedef enum logic [1:0] {
    is_32k = 2'b00,
    is_8k  = 2'b01,
    is_512 = 2'b10,
    is_64  = 2'b11
  } wdt_is_e;

  // Stored control byte, bit 7 down to bit 0
  typedef struct packed {
    // Stop counting
    logic       hold;
    // NMI bits, not implemented
    logic [1:0] unused;
    // 1 interval mode, 0 watchdog mode
    logic       tmsel;
    // Counter clear, write only so always zero here
    logic       cntcl;
    // 1 aclk_en, 0 smclk_en
    logic       ssel;
    wdt_is_e    is;
  } wdtctl_t;

  // Flag strobes from interrupt controller and CPU
  typedef struct packed {
    logic sw_set;
    logic sw_clr;
    // Interrupt acknowledge
    logic irq_clr;
  } wdt_flag_ctl_t;

endpackage

/* source/wdt_macros.svh */
/* Watchdog timer constants
   Register address, keys, masks, bus widths and interval taps */

`ifndef WDT_MACROS_SVH
`define WDT_MACROS_SVH

// Peripheral bus widths
`define WDT_ADDR_W    14
`define WDT_DATA_W    16

// WDTCTL byte address
`define WDT_BASE_ADDR 15'h0120

// Write password, checked on the high byte
`define WDT_PW        8'h5A

// Key returned in the high byte on reads
`define WDT_RD_KEY    8'h69

// Stored bits of WDTCTL
`define WDT_CTL_MASK  8'h97

// Counter width
`define WDT_CNT_W     16

// Interval taps, 32768 / 8192 / 512 / 64 ticks
`define WDT_TAP_0     15
`define WDT_TAP_1     13
`define WDT_TAP_2     9
`define WDT_TAP_3     6

`endif

/* source/wdt_regs.sv */
/* Watchdog register block
   Decodes WDTCTL, checks the password and returns read data */

`timescale 1ns/1ns
`include "wdt_macros.svh"

module wdt_regs
  import wdt_bus_pkg::*;
  import wdt_ctl_pkg::*;
(
  input  logic      mclk,
  input  logic      puc_rst,
  input  per_req_t  per_req,
  output per_data_t per_dout,
  output wdtctl_t   wdtctl,
  output logic      cnt_clr_sw,
  output logic      pw_error
);

  // Byte base address of WDTCTL
  localparam logic [14:0] BASE_BYTE = `WDT_BASE_ADDR;

  ////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////

  logic reg_sel;
  logic reg_wr;
  logic reg_rd;

  // Single word register, so bit 0 of the word address must be low
  assign reg_sel = per_req.en &
                   (per_req.addr[`WDT_ADDR_W-1:1] == BASE_BYTE[14:2]) &
                   ~per_req.addr[0];

  // Any byte enable makes a write
  assign reg_wr = reg_sel & (|per_req.we);
  assign reg_rd = reg_sel & ~(|per_req.we);

  ////////////////////////////////////////////////////////////
  // WDTCTL storage
  ////////////////////////////////////////////////////////////

  // Masked low byte, stored even with a bad key
  always_ff @(posedge mclk or posedge puc_rst) begin
    if (puc_rst) begin
      wdtctl <= '0;
    end else if (reg_wr) begin
      wdtctl <= wdtctl_t'(per_req.din[7:0] & `WDT_CTL_MASK);
    end
  end

  // Counter clear request, CNTCL is never stored
  assign cnt_clr_sw = reg_wr & per_req.din[3];

  // Wrong key in the high byte
  assign pw_error = reg_wr & (per_req.din[`WDT_DATA_W-1:8] != `WDT_PW);

  ////////////////////////////////////////////////////////////
  // Read data
  ////////////////////////////////////////////////////////////

  // Zero unless this register is read
  always_comb begin
    per_dout = '0;
    if (reg_rd) begin
      per_dout = {`WDT_RD_KEY, wdtctl};
    end
  end

endmodule

/* source/wdt_status.sv */
/* Watchdog status block
   Interrupt flag, interval interrupt and watchdog reset pulse */

`timescale 1ns/1ns

module wdt_status
  import wdt_ctl_pkg::*;
(
  input  logic          mclk,
  input  logic          por,
  input  wdtctl_t       wdtctl,
  input  logic          interval_evt,
  input  logic          pw_error,
  input  wdt_flag_ctl_t flag_ctl,
  input  logic          wdtie,
  output logic          wdtifg,
  output logic          wdt_irq,
  output logic          wdt_reset
);

  logic flag_set;
  logic flag_clr;

  ////////////////////////////////////////////////////////////
  // Interrupt flag
  ////////////////////////////////////////////////////////////

  // Hardware events or software set
  assign flag_set = interval_evt | pw_error | flag_ctl.sw_set;

  // Acknowledge only clears in interval mode
  assign flag_clr = flag_ctl.sw_clr | (flag_ctl.irq_clr & wdtctl.tmsel);

  // Kept under por so the cause survives a watchdog reset
  always_ff @(posedge mclk or posedge por) begin
    if (por) begin
      wdtifg <= 1'b0;
    end else if (flag_set) begin
      wdtifg <= 1'b1;
    end else if (flag_clr) begin
      wdtifg <= 1'b0;
    end
  end

  // Interrupt in interval mode only
  assign wdt_irq = wdtctl.tmsel & wdtifg & wdtie;

  ////////////////////////////////////////////////////////////
  // Reset pulse
  ////////////////////////////////////////////////////////////

  // One cycle after a bad key or a set event in watchdog mode
  always_ff @(posedge mclk or posedge por) begin
    if (por) begin
      wdt_reset <= 1'b0;
    end else begin
      wdt_reset <= pw_error | (flag_set & ~wdtctl.tmsel);
    end
  end

endmodule

/* source/wdt_top.sv */
/* Watchdog timer top level
   Register block, counter and status block on mclk */

`timescale 1ns/1ns

module wdt_top
  import wdt_bus_pkg::*;
  import wdt_ctl_pkg::*;
(
  input  logic          mclk,
  input  logic          puc_rst,
  input  logic          por,
  input  per_req_t      per_req,
  output per_data_t     per_dout,
  input  logic          smclk_en,
  input  logic          aclk_en,
  input  logic          dbg_freeze,
  input  logic          wdtie,
  input  wdt_flag_ctl_t flag_ctl,
  output logic          wdtifg,
  output logic          wdt_irq,
  output logic          wdt_reset
);

  // Control byte to counter and status
  wdtctl_t wdtctl;

  // Strobes between blocks
  logic    cnt_clr_sw;
  logic    pw_error;
  logic    interval_evt;

  ////////////////////////////////////////////////////////////
  // Blocks
  ////////////////////////////////////////////////////////////

  wdt_regs u_regs (
    .mclk       (mclk),
    .puc_rst    (puc_rst),
    .per_req    (per_req),
    .per_dout   (per_dout),
    .wdtctl     (wdtctl),
    .cnt_clr_sw (cnt_clr_sw),
    .pw_error   (pw_error)
  );

  wdt_counter u_counter (
    .mclk         (mclk),
    .puc_rst      (puc_rst),
    .wdtctl       (wdtctl),
    .smclk_en     (smclk_en),
    .aclk_en      (aclk_en),
    .dbg_freeze   (dbg_freeze),
    .cnt_clr_sw   (cnt_clr_sw),
    .pw_error     (pw_error),
    .interval_evt (interval_evt)
  );

  // Flag and reset live on por
  wdt_status u_status (
    .mclk         (mclk),
    .por          (por),
    .wdtctl       (wdtctl),
    .interval_evt (interval_evt),
    .pw_error     (pw_error),
    .flag_ctl     (flag_ctl),
    .wdtie        (wdtie),
    .wdtifg       (wdtifg),
    .wdt_irq      (wdt_irq),
    .wdt_reset    (wdt_reset)
  );

endmodule

/* verification/tb_wdt_top.sv */
/* Watchdog timer testbench
   Random stimulus from an LFSR, checked every cycle against a cycle model */

`timescale 1ns/1ns
`include "wdt_macros.svh"

module tb_wdt_top
  import wdt_bus_pkg::*;
  import wdt_ctl_pkg::*;
();

  localparam int          CLK_PERIOD   = 20;
  localparam int          RESET_CYCLES = 10;
  localparam logic [15:0] SEED         = 16'd53;
  localparam int          LEN_SHORT    = 300;
  localparam int          LEN_LONG     = 800;
  // Two short phases, five long ones, two bus cycles in front of each
  localparam int          TEST_CYCLES  = 2 * LEN_SHORT + 5 * LEN_LONG + 7 * 2;
  localparam int          TIMEOUT      = RESET_CYCLES + TEST_CYCLES + 200;
  localparam logic [14:0] BASE_BYTE    = `WDT_BASE_ADDR;
  // Word address of WDTCTL on the bus
  localparam logic [13:0] REG_ADDR     = BASE_BYTE[14:1];
  localparam logic [7:0]  BAD_KEY      = 8'hA5;

  logic          mclk;
  logic          puc_rst;
  logic          por;
  per_req_t      per_req;
  per_data_t     per_dout;
  logic          smclk_en;
  logic          aclk_en;
  logic          dbg_freeze;
  logic          wdtie;
  wdt_flag_ctl_t flag_ctl;
  logic          wdtifg;
  logic          wdt_irq;
  logic          wdt_reset;

  logic [15:0]   lfsr;

  // Model state, value after the coming rising edge
  logic [7:0]    m_ctl;
  logic [15:0]   m_cnt;
  logic          m_ifg;
  logic          m_rst;

  wdt_top u_dut (
    .mclk       (mclk),
    .puc_rst    (puc_rst),
    .por        (por),
    .per_req    (per_req),
    .per_dout   (per_dout),
    .smclk_en   (smclk_en),
    .aclk_en    (aclk_en),
    .dbg_freeze (dbg_freeze),
    .wdtie      (wdtie),
    .flag_ctl   (flag_ctl),
    .wdtifg     (wdtifg),
    .wdt_irq    (wdt_irq),
    .wdt_reset  (wdt_reset)
  );

  initial begin
    mclk = 1'b0;
    forever #(CLK_PERIOD / 2) mclk = ~mclk;
  end

  ////////////////////////////////////////////////////////////
  // Random bits
  ////////////////////////////////////////////////////////////

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One step per bit
  task automatic take_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v[i] = lfsr[0];
    end
  endtask

  task automatic check_val(input string name, input logic [15:0] got,
                           input logic [15:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] t=%0t %s got %h expected %h", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Cycle model and checks
  ////////////////////////////////////////////////////////////

  // Inputs are stable here until the next rising edge
  always @(negedge mclk) begin : model
    logic        sel;
    logic        wr;
    logic        rd;
    logic        tick;
    logic        evt;
    logic        pwe;
    logic        fset;
    logic        fclr;
    logic [15:0] cnt_inc;
    logic [15:0] exp_dout;
    logic [3:0]  tap;
    sel = per_req.en && (per_req.addr[13:1] == REG_ADDR[13:1]) && !per_req.addr[0];
    wr  = sel && (per_req.we != 2'b00);
    rd  = sel && (per_req.we == 2'b00);
    exp_dout = rd ? {`WDT_RD_KEY, m_ctl} : 16'h0000;
    check_val("per_dout", per_dout, exp_dout);
    check_val("wdtifg", {15'd0, wdtifg}, {15'd0, m_ifg});
    check_val("wdt_irq", {15'd0, wdt_irq}, {15'd0, m_ctl[4] & m_ifg & wdtie});
    check_val("wdt_reset", {15'd0, wdt_reset}, {15'd0, m_rst});
    // Tap from IS, 2^tap ticks per interval
    case (wdt_is_e'(m_ctl[1:0]))
      is_32k:  tap = `WDT_TAP_0;
      is_8k:   tap = `WDT_TAP_1;
      is_512:  tap = `WDT_TAP_2;
      default: tap = `WDT_TAP_3;
    endcase
    tick    = !m_ctl[7] && !dbg_freeze && (m_ctl[2] ? aclk_en : smclk_en);
    cnt_inc = m_cnt + 16'd1;
    evt     = tick && cnt_inc[tap];
    pwe     = wr && (per_req.din[15:8] != `WDT_PW);
    fset    = evt || pwe || flag_ctl.sw_set;
    fclr    = flag_ctl.sw_clr || (flag_ctl.irq_clr && m_ctl[4]);
    if (puc_rst || por) begin
      m_ctl = 8'h00;
      m_cnt = 16'h0000;
      m_ifg = 1'b0;
      m_rst = 1'b0;
    end else begin
      m_rst = pwe || (fset && !m_ctl[4]);
      if (fset) begin
        m_ifg = 1'b1;
      end else if (fclr) begin
        m_ifg = 1'b0;
      end
      // Clear wins over a tick
      if ((wr && per_req.din[3]) || pwe || evt) begin
        m_cnt = 16'h0000;
      end else if (tick) begin
        m_cnt = cnt_inc;
      end
      if (wr) begin
        m_ctl = per_req.din[7:0] & `WDT_CTL_MASK;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // Random enables and strobes, a bus access in about 1 of 8 cycles
  task automatic drive_cycle(input logic [7:0] ctl_byte, input logic mix);
    logic [15:0]   r;
    logic [15:0]   f;
    logic [15:0]   b;
    logic [15:0]   a;
    per_req_t      req;
    wdt_flag_ctl_t fc;
    take_bits(8, r);
    take_bits(15, f);
    take_bits(5, b);
    req = '0;
    // Strobes rare enough for an interval to complete
    fc.sw_set  = &f[4:0];
    fc.sw_clr  = &f[9:5];
    fc.irq_clr = &f[14:10];
    if (b[2:0] == 3'd0) begin
      req.en   = 1'b1;
      req.addr = REG_ADDR;
      case (b[4:3])
        2'd1: begin
          take_bits(14, a);
          req.addr = a[13:0];
        end
        2'd2: begin
          req.en = 1'b0;
          req.we = r[7:6];
        end
        2'd3: begin
          // CNTCL or wrong key, same control byte
          if (mix) begin
            take_bits(1, a);
            req.we  = 2'b11;
            req.din = a[0] ? {BAD_KEY, ctl_byte} : {`WDT_PW, ctl_byte | 8'h08};
          end
        end
        default: req.we = 2'b00;
      endcase
    end
    @(posedge mclk);
    smclk_en   <= r[0];
    aclk_en    <= r[1];
    dbg_freeze <= &r[4:2];
    wdtie      <= r[5];
    flag_ctl   <= fc;
    per_req    <= req;
  endtask

  // Program WDTCTL, read it back, then run random cycles
  task automatic run_phase(input logic [7:0] ctl_byte, input int cycles, input logic mix);
    per_req_t req;
    req      = '0;
    req.addr = REG_ADDR;
    req.en   = 1'b1;
    req.we   = 2'b11;
    req.din  = {`WDT_PW, ctl_byte};
    @(posedge mclk);
    per_req <= req;
    req.we = 2'b00;
    @(posedge mclk);
    per_req <= req;
    repeat (cycles) drive_cycle(ctl_byte, mix);
  endtask

  initial begin : stim
    logic [15:0] rb;
    lfsr       = SEED;
    // Model starts in its reset state
    m_ctl      = 8'h00;
    m_cnt      = 16'h0000;
    m_ifg      = 1'b0;
    m_rst      = 1'b0;
    puc_rst    = 1'b1;
    por        = 1'b1;
    per_req    = '0;
    smclk_en   = 1'b0;
    aclk_en    = 1'b0;
    dbg_freeze = 1'b0;
    wdtie      = 1'b0;
    flag_ctl   = '0;
    repeat (RESET_CYCLES) @(posedge mclk);
    puc_rst <= 1'b0;
    por     <= 1'b0;
    // Random control byte with mixed bus traffic
    take_bits(8, rb);
    run_phase(rb[7:0], LEN_SHORT, 1'b1);
    // Interval mode, 64 ticks, smclk then aclk
    run_phase(8'h13, LEN_LONG, 1'b0);
    run_phase(8'h17, LEN_LONG, 1'b0);
    // Hold set
    run_phase(8'h93, LEN_SHORT, 1'b0);
    // Interval mode with CNTCL and bad key writes
    run_phase(8'h13, LEN_LONG, 1'b1);
    // Watchdog mode
    run_phase(8'h03, LEN_LONG, 1'b0);
    run_phase(8'h07, LEN_LONG, 1'b1);
    @(posedge mclk);
    $display("Simulation completed successfully");
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT * CLK_PERIOD);
    $display("Timeout: test did not finish within %0d cycles", TIMEOUT);
    $display("Simulation failed");
    $fatal(1);
  end

endmodule
